// File: Makefile
# Verilator build and run of the UART testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run tb_uart, scan $(LOG) for failure"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_uart \
		-f project.f -Mdir obj_dir -o tb_uart
	./obj_dir/tb_uart > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation reported a failure"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: bench/tb_uart.sv
`timescale 1ns/1ps
`default_nettype none

module tb_uart
   import uart_pkg::*;
();

   // --------------------
   // Bench constants
   // --------------------
   localparam int CLK_NS      = 100;
   localparam int TICK_CLKS   = 4;
   // 43.5 ticks per bit on the serial input
   localparam int BIT_CLKS    = 174;
   localparam int FRAMES      = 20;
   localparam int WATCHDOG_NS = FRAMES * 2 * 10 * BIT_CLKS * CLK_NS * 2;

   logic       clk;
   logic       arst_n;
   logic       tick_02us;
   logic       uart_rx;
   logic       uart_tx_write;
   uart_byte_t uart_tx_data;
   logic       uart_rx_read;
   logic       uart_tx;
   logic       uart_tx_busy;
   uart_rx_t   uart_rx_arr;

   integer seed;
   int     mismatches;
   int     failures;

   uart dut (
      .clk           (clk),
      .arst_n        (arst_n),
      .tick_02us     (tick_02us),
      .uart_rx       (uart_rx),
      .uart_tx_write (uart_tx_write),
      .uart_tx_data  (uart_tx_data),
      .uart_rx_read  (uart_rx_read),
      .uart_tx       (uart_tx),
      .uart_tx_busy  (uart_tx_busy),
      .uart_rx_arr   (uart_rx_arr)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_NS / 2) clk = ~clk;
   end

   // Free running one-clock tick every TICK_CLKS clocks
   initial begin
      tick_02us = 1'b0;
      forever begin
         repeat (TICK_CLKS - 1) @(posedge clk);
         #1 tick_02us = 1'b1;
         @(posedge clk);
         #1 tick_02us = 1'b0;
      end
   end

   // --------------------
   // Compare tasks
   // --------------------
   task automatic check_bit(input string name, input logic want, input logic got);
      if (got !== want) begin
         mismatches++;
         $display("Mismatch at %0t ns: %s expected %b, got %b", $time, name, want, got);
      end
   endtask

   task automatic check_byte(input string name, input uart_byte_t want, input uart_byte_t got);
      if (got !== want) begin
         mismatches++;
         $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, want, got);
      end
   endtask

   task automatic check_rx(input string name, input uart_rx_t want, input uart_rx_t got);
      if (got !== want) begin
         mismatches++;
         $display("Mismatch at %0t ns: %s expected v=%b o=%b d=%h, got v=%b o=%b d=%h",
                  $time, name, want.valid, want.oflow, want.data,
                  got.valid, got.oflow, got.data);
      end
   endtask

   // --------------------
   // Transmit side
   // --------------------
   // Waits until the transmitter is free again
   task automatic wait_tx_idle();
      int waited;
      waited = 0;
      while (uart_tx_busy !== 1'b0 && waited < 12 * BIT_CLKS) begin
         @(negedge clk);
         waited++;
      end
      if (uart_tx_busy !== 1'b0) begin
         failures++;
         $display("Timeout at %0t ns: uart_tx_busy never fell", $time);
      end
   endtask

   // Line model that starts the frame on the falling edge
   // Each bit sampled 21 ticks after its nominal start on a 43.4 tick raster
   task automatic decode_line(output logic [9:0] bits, output logic seen);
      int waited;
      int last;
      int target;
      waited = 0;
      last   = 0;
      bits   = '1;
      while (uart_tx !== 1'b0 && waited < 8 * TICK_CLKS) begin
         @(negedge clk);
         waited++;
      end
      seen = (uart_tx === 1'b0);
      if (!seen) begin
         failures++;
         $display("Timeout at %0t ns: no start bit on uart_tx after the write", $time);
      end
      else begin
         for (int k = 0; k < 10; k++) begin
            // Tenths of a tick kept in integer math
            target = (k * 434 + 210) * TICK_CLKS / 10;
            repeat (target - last) @(negedge clk);
            last    = target;
            bits[k] = uart_tx;
            // Busy covers the whole frame up to the end of stop
            check_bit("uart_tx_busy", 1'b1, uart_tx_busy);
         end
         // Stop bit ends 434 ticks after the falling edge
         repeat (433 * TICK_CLKS - last) @(negedge clk);
         check_bit("uart_tx_busy", 1'b1, uart_tx_busy);
         repeat (2 * TICK_CLKS) @(negedge clk);
         check_bit("uart_tx_busy", 1'b0, uart_tx_busy);
      end
   endtask

   // Writes one byte and optionally a second one mid-frame that must be lost
   task automatic send_tx_frame(input uart_byte_t b, input logic extra);
      logic [9:0] bits;
      logic       seen;
      wait_tx_idle();
      @(posedge clk);
      #1 uart_tx_write = 1'b1;
      uart_tx_data = b;
      @(posedge clk);
      #1 uart_tx_write = 1'b0;
      check_bit("uart_tx_busy", 1'b1, uart_tx_busy);
      fork
         decode_line(bits, seen);
         if (extra) begin
            repeat (2 * BIT_CLKS) @(posedge clk);
            #1 uart_tx_write = 1'b1;
            uart_tx_data = ~b;
            @(posedge clk);
            #1 uart_tx_write = 1'b0;
         end
      join
      if (seen) begin
         check_bit("uart_tx start bit", 1'b0, bits[0]);
         check_byte("uart_tx frame data", b, bits[8:1]);
         check_bit("uart_tx stop bit", 1'b1, bits[9]);
      end
      wait_tx_idle();
      if (extra) begin
         // Dropped write must not start another frame
         repeat (BIT_CLKS) @(negedge clk);
         check_bit("uart_tx_busy", 1'b0, uart_tx_busy);
         check_bit("uart_tx", 1'b1, uart_tx);
      end
   endtask

   // --------------------
   // Receive side
   // --------------------
   // Serial driver sending the start bit and data LSB first, then one stop bit
   task automatic send_serial(input uart_byte_t b);
      logic [9:0] frame;
      frame = {1'b1, b, 1'b0};
      for (int i = 0; i < 10; i++) begin
         @(posedge clk);
         #1 uart_rx = frame[i];
         repeat (BIT_CLKS - 1) @(posedge clk);
      end
   endtask

   task automatic wait_rx_flag(input logic want_oflow);
      int   waited;
      logic seen;
      waited = 0;
      @(negedge clk);
      seen   = want_oflow ? uart_rx_arr.oflow : uart_rx_arr.valid;
      while (!seen && waited < 4 * BIT_CLKS) begin
         @(negedge clk);
         seen = want_oflow ? uart_rx_arr.oflow : uart_rx_arr.valid;
         waited++;
      end
      if (!seen) begin
         failures++;
         $display("Timeout at %0t ns: holding register flag never rose", $time);
      end
   endtask

   task automatic pulse_read();
      @(posedge clk);
      #1 uart_rx_read = 1'b1;
      @(posedge clk);
      #1 uart_rx_read = 1'b0;
   endtask

   // One frame in, checked, then read out
   task automatic receive_frame(input uart_byte_t b);
      uart_rx_t want;
      send_serial(b);
      wait_rx_flag(1'b0);
      want.valid = 1'b1;
      want.oflow = 1'b0;
      want.data  = b;
      check_rx("uart_rx_arr", want, uart_rx_arr);
      pulse_read();
      check_bit("uart_rx_arr.valid", 1'b0, uart_rx_arr.valid);
   endtask

   // Second unread frame raises oflow and keeps the first byte
   task automatic overflow_pair(input uart_byte_t first, input uart_byte_t second);
      uart_rx_t want;
      send_serial(first);
      send_serial(second);
      wait_rx_flag(1'b1);
      want.valid = 1'b1;
      want.oflow = 1'b1;
      want.data  = first;
      check_rx("uart_rx_arr", want, uart_rx_arr);
      pulse_read();
      want.valid = 1'b0;
      want.oflow = 1'b0;
      check_rx("uart_rx_arr", want, uart_rx_arr);
   endtask

   // --------------------
   // Test sequence
   // --------------------
   initial begin
      uart_byte_t tx_b;
      uart_byte_t rx_b;
      seed          = 79316;
      mismatches    = 0;
      failures      = 0;
      arst_n        = 1'b0;
      uart_rx       = 1'b1;
      uart_tx_write = 1'b0;
      uart_tx_data  = '0;
      uart_rx_read  = 1'b0;

      repeat (10) @(posedge clk);
      #1 arst_n = 1'b1;
      @(negedge clk);
      check_bit("uart_tx", 1'b1, uart_tx);
      check_bit("uart_tx_busy", 1'b0, uart_tx_busy);
      check_rx("uart_rx_arr", '0, uart_rx_arr);

      for (int i = 0; i < FRAMES; i++) begin
         tx_b = uart_byte_t'($random(seed));
         send_tx_frame(tx_b, 1'b0);
      end
      tx_b = uart_byte_t'($random(seed));
      send_tx_frame(tx_b, 1'b1);

      for (int i = 0; i < FRAMES; i++) begin
         rx_b = uart_byte_t'($random(seed));
         receive_frame(rx_b);
      end
      tx_b = uart_byte_t'($random(seed));
      rx_b = uart_byte_t'($random(seed));
      overflow_pair(tx_b, rx_b);

      // Both directions at once
      for (int i = 0; i < FRAMES; i++) begin
         tx_b = uart_byte_t'($random(seed));
         rx_b = uart_byte_t'($random(seed));
         fork
            send_tx_frame(tx_b, 1'b0);
            receive_frame(rx_b);
         join
      end

      $display("Run complete: %0d mismatches, %0d other failures", mismatches, failures);
      if (mismatches == 0 && failures == 0) begin
         $display("TEST PASSED");
      end
      else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   // Bound on run time
   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
      $display("TEST FAILED");
      $finish;
   end

endmodule : tb_uart

`default_nettype wire

// File: project.f
+incdir+source
source/uart_pkg.sv
source/bit_timer.sv
source/uart_rx.sv
source/uart_tx.sv
source/rx_holding.sv
source/uart.sv
bench/tb_uart.sv

// File: source/bit_timer.sv
`timescale 1ns/1ps
`default_nettype none

module bit_timer
   import uart_pkg::*;
(
   input  logic     clk,
   input  logic     arst_n,
   input  logic     tick_02us,
   input  logic     run,
   input  logic     load,
   input  cnt02us_t load_val,
   output logic     next_bit
);

   // Remaining ticks in the current bit period
   cnt02us_t cnt;

   // --------------------
   // Countdown
   // --------------------
   always_ff @(posedge clk) begin
      if (!arst_n) begin
         cnt <= '0;
      end
      else if (load) begin
         // Reload has priority over the tick
         cnt <= load_val;
      end
      else if (tick_02us && run) begin
         cnt <= cnt02us_t'(cnt - cnt02us_t'(1));
      end
   end

   // --------------------
   // Period end
   // --------------------
   // The tick that finds the count at zero closes the period
   // Owner FSM steps and reloads on this same cycle
   assign next_bit = tick_02us & (cnt == '0);

endmodule : bit_timer

`default_nettype wire

// File: source/rx_holding.sv
`timescale 1ns/1ps
`default_nettype none

module rx_holding
   import uart_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n,
   input  logic       rx_done,
   input  uart_byte_t rx_byte,
   input  logic       uart_rx_read,
   output uart_rx_t   uart_rx_arr
);

   // --------------------
   // Holding register
   // --------------------
   // One byte deep buffer seen by software
   always_ff @(posedge clk) begin
      if (!arst_n) begin
         uart_rx_arr.valid <= 1'b0;
         uart_rx_arr.oflow <= 1'b0;
         uart_rx_arr.data  <= '0;
      end
      else begin
         // Read clears both flags
         if (uart_rx_read) begin
            uart_rx_arr.valid <= 1'b0;
            uart_rx_arr.oflow <= 1'b0;
         end

         // Hardware set comes later and wins over the read
         if (rx_done) begin
            if (uart_rx_arr.valid) begin
               // Unread byte stays, new one is lost
               uart_rx_arr.oflow <= 1'b1;
            end
            else begin
               uart_rx_arr.valid <= 1'b1;
               uart_rx_arr.data  <= rx_byte;
            end
         end
      end
   end

endmodule : rx_holding

`default_nettype wire

// File: source/uart.sv
`timescale 1ns/1ps
`default_nettype none

module uart
   import uart_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n,
   input  logic       tick_02us,
   input  logic       uart_rx,
   input  logic       uart_tx_write,
   input  uart_byte_t uart_tx_data,
   input  logic       uart_rx_read,
   output logic       uart_tx,
   output logic       uart_tx_busy,
   output uart_rx_t   uart_rx_arr
);

   // Deserializer to buffer handoff
   logic       rx_done;
   uart_byte_t rx_byte;

   // --------------------
   // Receive path
   // --------------------
   uart_rx u_rx (
      .clk       (clk),
      .arst_n    (arst_n),
      .tick_02us (tick_02us),
      .uart_rx   (uart_rx),
      .rx_done   (rx_done),
      .rx_byte   (rx_byte)
   );

   // Software facing byte with valid and overflow
   rx_holding u_hold (
      .clk          (clk),
      .arst_n       (arst_n),
      .rx_done      (rx_done),
      .rx_byte      (rx_byte),
      .uart_rx_read (uart_rx_read),
      .uart_rx_arr  (uart_rx_arr)
   );

   // --------------------
   // Transmit path
   // --------------------
   // Independent of the receiver apart from the shared tick
   uart_tx u_tx (
      .clk           (clk),
      .arst_n        (arst_n),
      .tick_02us     (tick_02us),
      .uart_tx_write (uart_tx_write),
      .uart_tx_data  (uart_tx_data),
      .uart_tx       (uart_tx),
      .uart_tx_busy  (uart_tx_busy)
   );

endmodule : uart

`default_nettype wire

// File: source/uart_cfg.svh
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// --------------------
// Frame format
// --------------------

// Data bits per frame, sent LSB first
`define UART_DATA_BITS 8

// Width of the per-bit tick counter
`define UART_CNT_W 8

// --------------------
// Rx wait table
// --------------------
// Reload values in 0.2 us ticks minus one
// First wait spans start bit plus half of D0 (about 13 us)
// Later waits alternate 8.6 and 8.8 us around the 8.68 us bit
// so the sample point drifts no more than 0.2 us from centre
`define UART_RX_WAIT_D0   64
`define UART_RX_WAIT_D1   42
`define UART_RX_WAIT_D2   42
`define UART_RX_WAIT_D3   43
`define UART_RX_WAIT_D4   42
`define UART_RX_WAIT_D5   43
`define UART_RX_WAIT_D6   42
`define UART_RX_WAIT_D7   42
`define UART_RX_WAIT_STOP 43

// --------------------
// Tx wait table
// --------------------
// Start gets one extra tick for aligning the line to the tick grid
// Bit edges stay within 0.1 us of the ideal 8.68 us raster
`define UART_TX_WAIT_START 43
`define UART_TX_WAIT_D0    43
`define UART_TX_WAIT_D1    42
`define UART_TX_WAIT_D2    43
`define UART_TX_WAIT_D3    42
`define UART_TX_WAIT_D4    42
`define UART_TX_WAIT_D5    43
`define UART_TX_WAIT_D6    42
`define UART_TX_WAIT_D7    43
`define UART_TX_WAIT_STOP  42

`endif

// File: source/uart_pkg.sv
`default_nettype none

`include "uart_cfg.svh"

package uart_pkg;

   // --------------------
   // Bit-level FSM state
   // --------------------
   // Data states carry their bit index in the low three bits
   // Bit 3 is clear only for D0 to D7
   typedef enum logic [3:0] {
      D0    = 4'd0,
      D1    = 4'd1,
      D2    = 4'd2,
      D3    = 4'd3,
      D4    = 4'd4,
      D5    = 4'd5,
      D6    = 4'd6,
      D7    = 4'd7,
      // Single stop bit, no parity
      STOP  = 4'd8,
      IDLE  = 4'd14,
      // Only used by the transmitter
      START = 4'd15
   } uart_state_t;

   // Countdown of 0.2 us ticks within one bit period
   typedef logic [`UART_CNT_W-1:0] cnt02us_t;

   // One payload byte
   typedef logic [`UART_DATA_BITS-1:0] uart_byte_t;

   // --------------------
   // Rx holding register
   // --------------------
   // Both flags are cleared by a read
   typedef struct packed {
      logic       valid;
      logic       oflow;
      uart_byte_t data;
   } uart_rx_t;

endpackage : uart_pkg

`default_nettype wire

// File: source/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_cfg.svh"

module uart_rx
   import uart_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n,
   input  logic       tick_02us,
   input  logic       uart_rx,
   output logic       rx_done,
   output uart_byte_t rx_byte
);

   uart_state_t rx_state;
   uart_state_t nxt_state;
   cnt02us_t    wait_val;
   logic        rx_next_bit;
   logic        is_data;
   uart_byte_t  rx_shift;

   // D0 to D7 are the only codes with bit 3 clear
   assign is_data = ~rx_state[3];

   // --------------------
   // Bit timing
   // --------------------
   // Held loaded with the D0 wait while idle
   // so counting starts right at the start edge
   bit_timer u_timer (
      .clk       (clk),
      .arst_n    (arst_n),
      .tick_02us (tick_02us),
      .run       (rx_state != IDLE),
      .load      ((rx_state == IDLE) | rx_next_bit),
      .load_val  (wait_val),
      .next_bit  (rx_next_bit)
   );

   // Wait until the sample point of the following bit
   always_comb begin
      unique case (rx_state)
         D0:      wait_val = cnt02us_t'(`UART_RX_WAIT_D1);
         D1:      wait_val = cnt02us_t'(`UART_RX_WAIT_D2);
         D2:      wait_val = cnt02us_t'(`UART_RX_WAIT_D3);
         D3:      wait_val = cnt02us_t'(`UART_RX_WAIT_D4);
         D4:      wait_val = cnt02us_t'(`UART_RX_WAIT_D5);
         D5:      wait_val = cnt02us_t'(`UART_RX_WAIT_D6);
         D6:      wait_val = cnt02us_t'(`UART_RX_WAIT_D7);
         D7:      wait_val = cnt02us_t'(`UART_RX_WAIT_STOP);
         // Idle and stop prepare for the next start bit
         default: wait_val = cnt02us_t'(`UART_RX_WAIT_D0);
      endcase
   end

   // Successor state
   always_comb begin
      unique case (rx_state)
         IDLE:    nxt_state = D0;
         D7:      nxt_state = STOP;
         STOP:    nxt_state = IDLE;
         // Data states count up by one
         default: nxt_state = uart_state_t'(rx_state + 4'd1);
      endcase
   end

   // --------------------
   // FSM
   // --------------------
   always_ff @(posedge clk) begin
      if (!arst_n) begin
         rx_state <= IDLE;
      end
      else if (rx_state == IDLE) begin
         // Low line marks the start edge
         if (!uart_rx) begin
            rx_state <= nxt_state;
         end
      end
      else if (rx_next_bit) begin
         rx_state <= nxt_state;
      end
   end

   // Sample data bits at their centre
   always_ff @(posedge clk) begin
      if (rx_next_bit && is_data) begin
         // MSB arrives last
         rx_shift <= {uart_rx, rx_shift[`UART_DATA_BITS-1:1]};
      end
   end

   // --------------------
   // Byte out
   // --------------------
   // Stop bit level is not checked
   assign rx_done = rx_next_bit & (rx_state == STOP);
   assign rx_byte = rx_shift;

endmodule : uart_rx

`default_nettype wire

// File: source/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_cfg.svh"

module uart_tx
   import uart_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n,
   input  logic       tick_02us,
   input  logic       uart_tx_write,
   input  uart_byte_t uart_tx_data,
   output logic       uart_tx,
   output logic       uart_tx_busy
);

   uart_state_t tx_state;
   uart_state_t nxt_state;
   cnt02us_t    wait_val;
   logic        nxt_line;
   logic        tx_next_bit;
   logic [2:0]  bit_idx;
   uart_byte_t  tx_data;

   // Data states encode the bit being sent
   assign bit_idx = tx_state[2:0];

   // --------------------
   // Bit timing
   // --------------------
   bit_timer u_timer (
      .clk       (clk),
      .arst_n    (arst_n),
      .tick_02us (tick_02us),
      .run       (tx_state != IDLE),
      .load      ((tx_state == IDLE) | tx_next_bit),
      .load_val  (wait_val),
      .next_bit  (tx_next_bit)
   );

   // Length of the bit that follows the current one
   always_comb begin
      unique case (tx_state)
         START:   wait_val = cnt02us_t'(`UART_TX_WAIT_D0);
         D0:      wait_val = cnt02us_t'(`UART_TX_WAIT_D1);
         D1:      wait_val = cnt02us_t'(`UART_TX_WAIT_D2);
         D2:      wait_val = cnt02us_t'(`UART_TX_WAIT_D3);
         D3:      wait_val = cnt02us_t'(`UART_TX_WAIT_D4);
         D4:      wait_val = cnt02us_t'(`UART_TX_WAIT_D5);
         D5:      wait_val = cnt02us_t'(`UART_TX_WAIT_D6);
         D6:      wait_val = cnt02us_t'(`UART_TX_WAIT_D7);
         D7:      wait_val = cnt02us_t'(`UART_TX_WAIT_STOP);
         // Idle and stop prepare the start bit
         default: wait_val = cnt02us_t'(`UART_TX_WAIT_START);
      endcase
   end

   // Successor state and the line level it drives
   always_comb begin
      unique case (tx_state)
         IDLE: begin
            nxt_state = START;
            nxt_line  = 1'b1;
         end
         START: begin
            // LSB goes out first
            nxt_state = D0;
            nxt_line  = tx_data[0];
         end
         D7: begin
            nxt_state = STOP;
            nxt_line  = 1'b1;
         end
         STOP: begin
            nxt_state = IDLE;
            nxt_line  = 1'b1;
         end
         default: begin
            nxt_state = uart_state_t'(tx_state + 4'd1);
            nxt_line  = tx_data[bit_idx + 3'd1];
         end
      endcase
   end

   // --------------------
   // FSM and line driver
   // --------------------
   always_ff @(posedge clk) begin
      if (!arst_n) begin
         tx_state <= IDLE;
         uart_tx  <= 1'b1;
      end
      else begin
         unique case (tx_state)
            IDLE: begin
               // Line rests at stop level
               uart_tx <= 1'b1;
               if (uart_tx_write) begin
                  tx_state <= nxt_state;
               end
            end
            START: begin
               // First tick after the write pulls the line low
               if (tick_02us) begin
                  uart_tx <= 1'b0;
               end
               if (tx_next_bit) begin
                  uart_tx  <= nxt_line;
                  tx_state <= nxt_state;
               end
            end
            default: begin
               if (tx_next_bit) begin
                  uart_tx  <= nxt_line;
                  tx_state <= nxt_state;
               end
            end
         endcase
      end
   end

   // Writes are taken only while idle
   always_ff @(posedge clk) begin
      if ((tx_state == IDLE) && uart_tx_write) begin
         tx_data <= uart_tx_data;
      end
   end

   assign uart_tx_busy = (tx_state != IDLE);

endmodule : uart_tx

`default_nettype wire
